//--- common/fetch_pkg.sv
package fetch_pkg;

    // address and word geometry
    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;
    localparam int WORD_BYTES = 4;
    localparam int WORD_OFFSET_BITS = 2;

    // a block holds two instruction words
    localparam int BLOCK_WORDS = 2;
    localparam int BLOCK_BYTES = 8;
    localparam int BLOCK_OFFSET_BITS = 3;
    localparam int BLOCK_WORD_BITS = 1;

    // memory tags, tag 0 means no transaction
    localparam int NUM_MEM_TAGS = 16;

    // fetch width and buffer room
    localparam int FETCH_WIDTH = 2;

    // direct mapped icache, one block per line
    localparam int ICACHE_LINES = 32;
    localparam int ICACHE_INDEX_BITS = 5;
    localparam int ICACHE_TAG_LSB = BLOCK_OFFSET_BITS + ICACHE_INDEX_BITS;
    localparam int ICACHE_TAG_BITS = ADDR_BITS - ICACHE_TAG_LSB;

    // blocks the prefetch pointer may run past the fetch block
    localparam int PREFETCH_DEPTH = 4;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BLOCK_WORDS*WORD_BITS-1:0] block_t;
    typedef logic [3:0] mem_tag_t;
    typedef logic [1:0] ibuff_count_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'h0,
        MEM_LOAD = 2'h1
    } mem_command_t;

    typedef enum logic [1:0] {
        BR_NONE   = 2'h0,
        BR_TAKEN  = 2'h1,
        BR_SQUASH = 2'h2
    } br_task_t;

    // one instruction handed to the buffer
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] inst;
        addr_t                pc;
        addr_t                npc;
    } inst_packet_t;

endpackage

//--- source/inst_select.sv
module inst_select (
    input  fetch_pkg::addr_t        fetch_pc,
    input  fetch_pkg::ibuff_count_t ibuff_open,

    // cache read of the pc block
    input  logic                    read_hit,
    input  fetch_pkg::block_t       read_data,

    // block returning from memory this cycle
    input  logic                    fill_valid,
    input  fetch_pkg::addr_t        fill_addr,
    input  fetch_pkg::block_t       fill_data,

    output fetch_pkg::inst_packet_t [fetch_pkg::FETCH_WIDTH-1:0] sel_insts,
    output fetch_pkg::ibuff_count_t sel_count
);
    import fetch_pkg::*;

    logic                       fill_match;
    logic                       block_ok;
    block_t                     pc_block;
    logic [BLOCK_WORD_BITS-1:0] first_word;
    ibuff_count_t               words_left;

    // fill forwarding beats the cache, the cache copy is not written yet
    assign fill_match = fill_valid &&
        (fill_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS] == fetch_pc[ADDR_BITS-1:BLOCK_OFFSET_BITS]);
    assign block_ok = fill_match || read_hit;
    assign pc_block = fill_match ? fill_data : read_data;

    // word slot of the pc inside its block
    assign first_word = fetch_pc[BLOCK_OFFSET_BITS-1:WORD_OFFSET_BITS];
    assign words_left = ibuff_count_t'(BLOCK_WORDS - int'(first_word));

    // smallest of words left, fetch width and buffer room
    always_comb begin
        sel_count = '0;
        if (block_ok) begin
            sel_count = words_left;
            if (sel_count > ibuff_count_t'(FETCH_WIDTH)) begin
                sel_count = ibuff_count_t'(FETCH_WIDTH);
            end
            if (sel_count > ibuff_open) begin
                sel_count = ibuff_open;
            end
        end
    end

    // packets packed from slot 0, no prediction so npc is pc plus 4
    always_comb begin
        int slot;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot = int'(first_word) + i;
            sel_insts[i] = '0;
            // count never reaches past the end of the block
            if (i < int'(sel_count)) begin
                sel_insts[i].valid = 1'b1;
                sel_insts[i].inst  = pc_block[slot*WORD_BITS +: WORD_BITS];
                sel_insts[i].pc    = fetch_pc + addr_t'(i * WORD_BYTES);
                sel_insts[i].npc   = fetch_pc + addr_t'((i + 1) * WORD_BYTES);
            end
        end
    end

endmodule

//--- fetch/icache.sv
module icache (
    input  logic              clock,
    input  logic              rst,

    // fetch read and prefetch probe
    input  fetch_pkg::addr_t  read_addr,
    input  fetch_pkg::addr_t  probe_addr,

    // fill from memory
    input  logic              write_en,
    input  fetch_pkg::addr_t  write_addr,
    input  fetch_pkg::block_t write_data,

    output fetch_pkg::block_t read_data,
    output logic              read_hit,
    output logic              probe_hit
);
    import fetch_pkg::*;

    // per line state
    logic [ICACHE_LINES-1:0]    line_valid;
    logic [ICACHE_TAG_BITS-1:0] line_tag [ICACHE_LINES];
    block_t                     line_data [ICACHE_LINES];

    // index and tag split of each address
    logic [ICACHE_INDEX_BITS-1:0] read_index;
    logic [ICACHE_INDEX_BITS-1:0] probe_index;
    logic [ICACHE_INDEX_BITS-1:0] write_index;
    logic [ICACHE_TAG_BITS-1:0]   read_tag;
    logic [ICACHE_TAG_BITS-1:0]   probe_tag;
    logic [ICACHE_TAG_BITS-1:0]   write_tag;

    assign read_index  = read_addr[ICACHE_TAG_LSB-1:BLOCK_OFFSET_BITS];
    assign probe_index = probe_addr[ICACHE_TAG_LSB-1:BLOCK_OFFSET_BITS];
    assign write_index = write_addr[ICACHE_TAG_LSB-1:BLOCK_OFFSET_BITS];

    assign read_tag  = read_addr[ADDR_BITS-1:ICACHE_TAG_LSB];
    assign probe_tag = probe_addr[ADDR_BITS-1:ICACHE_TAG_LSB];
    assign write_tag = write_addr[ADDR_BITS-1:ICACHE_TAG_LSB];

    // both lookups are combinational
    assign read_data = line_data[read_index];
    assign read_hit  = line_valid[read_index] && (line_tag[read_index] == read_tag);

    // probe only needs the tag match, data is never read here
    assign probe_hit = line_valid[probe_index] && (line_tag[probe_index] == probe_tag);

    // valid bits survive redirects, only rst drops them
    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid <= '0;
        end else if (write_en) begin
            line_valid[write_index] <= 1'b1;
        end
    end

    // fill overwrites whatever was in the line
    always_ff @(posedge clock) begin
        if (write_en) begin
            line_tag[write_index]  <= write_tag;
            line_data[write_index] <= write_data;
        end
    end

endmodule

//--- fetch/mshr_table.sv
module mshr_table (
    input  logic               clock,
    input  logic               rst,
    input  logic               flush,

    // new transaction accepted by memory
    input  logic               alloc_en,
    input  fetch_pkg::mem_tag_t alloc_tag,
    input  fetch_pkg::addr_t   alloc_addr,

    // tag of the block coming back this cycle
    input  fetch_pkg::mem_tag_t retire_tag,

    // prefetch pointer check
    input  fetch_pkg::addr_t   lookup_addr,

    output logic               lookup_hit,
    output logic               full,
    output logic               retire_valid,
    output fetch_pkg::addr_t   retire_addr
);
    import fetch_pkg::*;

    // one slot per tag, slot 0 never filled
    logic [NUM_MEM_TAGS-1:0] entry_valid;
    addr_t                   entry_addr [NUM_MEM_TAGS];

    // compare block numbers, offsets are always zero anyway
    always_comb begin
        lookup_hit = 1'b0;
        for (int t = 1; t < NUM_MEM_TAGS; t++) begin
            if (entry_valid[t] &&
                entry_addr[t][ADDR_BITS-1:BLOCK_OFFSET_BITS] ==
                lookup_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS]) begin
                lookup_hit = 1'b1;
            end
        end
    end

    assign full = &entry_valid[NUM_MEM_TAGS-1:1];

    // unknown or flushed tags fall out here
    assign retire_valid = (retire_tag != '0) && entry_valid[retire_tag];
    assign retire_addr  = entry_addr[retire_tag];

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            // flush also wins over an allocate in the same cycle
            entry_valid <= '0;
        end else begin
            if (retire_valid) begin
                entry_valid[retire_tag] <= 1'b0;
            end
            // memory may hand back a tag that retires this same cycle
            if (alloc_en && alloc_tag != '0) begin
                entry_valid[alloc_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_en) begin
            entry_addr[alloc_tag] <= alloc_addr;
        end
    end

endmodule

//--- fetch/fetch.sv
module fetch (
    input  logic                    clock,
    input  logic                    rst,

    // redirect from the core
    input  fetch_pkg::addr_t        target,
    input  fetch_pkg::br_task_t     br_task,

    // free entries in the instruction buffer
    input  fetch_pkg::ibuff_count_t ibuff_open,

    // memory replies
    input  fetch_pkg::mem_tag_t     mem_transaction_tag,
    input  logic                    mem_transaction_handshake,
    input  fetch_pkg::mem_tag_t     mem_data_tag,
    input  fetch_pkg::block_t       mem_data,

    // memory request
    output logic                    mem_en,
    output fetch_pkg::addr_t        mem_addr,
    output fetch_pkg::mem_command_t mem_command,

    output fetch_pkg::inst_packet_t [fetch_pkg::FETCH_WIDTH-1:0] out_insts,
    output fetch_pkg::ibuff_count_t num_insts
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        FETCH    = 2'h0,
        PREFETCH = 2'h1,
        STALL    = 2'h2
    } fetch_state_t;

    fetch_state_t state, next_state;

    addr_t fetch_pc;
    addr_t prefetch_ptr;
    addr_t restart_pc;
    addr_t pc_block_addr;
    addr_t cand_addr;
    addr_t cand_dist;

    logic redirect;
    logic accept;
    logic in_window;
    logic cand_busy;
    logic walk_en;

    // icache and mshr wires
    block_t cache_read_data;
    logic   cache_read_hit;
    logic   cache_probe_hit;
    logic   mshr_lookup_hit;
    logic   mshr_full;
    logic   fill_valid;
    addr_t  fill_addr;

    inst_packet_t [FETCH_WIDTH-1:0] sel_insts;
    ibuff_count_t                   sel_count;

    assign redirect   = (br_task != BR_NONE);
    assign restart_pc = rst ? '0 : target;
    assign accept     = mem_en && mem_transaction_handshake && (mem_transaction_tag != '0);

    assign mem_command = mem_en ? MEM_LOAD : MEM_NONE;

    assign pc_block_addr = {fetch_pc[ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

    // pull the pointer along when the pc walks past it through cached blocks
    assign cand_addr = (prefetch_ptr < pc_block_addr) ? pc_block_addr : prefetch_ptr;
    assign cand_dist = (cand_addr - pc_block_addr) >> BLOCK_OFFSET_BITS;
    assign in_window = (cand_dist <= addr_t'(PREFETCH_DEPTH));

    // a block filling this cycle is not in the cache yet and already gone from the mshr
    assign cand_busy = cache_probe_hit || mshr_lookup_hit ||
        (fill_valid && fill_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS] ==
         cand_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS]);

    // one step of the walk per cycle while no request is outstanding
    assign walk_en = (state != STALL) && !mem_en && !mshr_full && in_window;

    // only a full mshr holds the walk back
    always_comb begin
        next_state = mshr_full ? STALL : PREFETCH;
    end

    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            state        <= FETCH;
            mem_en       <= 1'b0;
            fetch_pc     <= restart_pc;
            prefetch_ptr <= {restart_pc[ADDR_BITS-1:BLOCK_OFFSET_BITS],
                             {BLOCK_OFFSET_BITS{1'b0}}};
            out_insts    <= '0;
            num_insts    <= '0;
        end else begin
            state     <= next_state;
            out_insts <= sel_insts;
            num_insts <= sel_count;
            // pc moves by exactly what was handed out
            fetch_pc  <= fetch_pc + (addr_t'(sel_count) << WORD_OFFSET_BITS);
            if (accept) begin
                // next request waits a cycle so full is current
                mem_en <= 1'b0;
            end else if (walk_en) begin
                prefetch_ptr <= cand_addr + addr_t'(BLOCK_BYTES);
                mem_en       <= !cand_busy;
            end
        end
    end

    // request address held until the handshake
    always_ff @(posedge clock) begin
        if (walk_en && !cand_busy) begin
            mem_addr <= cand_addr;
        end
    end

    icache icache_0 (
        .clock      (clock),
        .rst        (rst),
        .read_addr  (fetch_pc),
        .probe_addr (cand_addr),
        .write_en   (fill_valid),
        .write_addr (fill_addr),
        .write_data (mem_data),
        .read_data  (cache_read_data),
        .read_hit   (cache_read_hit),
        .probe_hit  (cache_probe_hit)
    );

    mshr_table mshr_0 (
        .clock        (clock),
        .rst          (rst),
        .flush        (redirect),
        .alloc_en     (accept),
        .alloc_tag    (mem_transaction_tag),
        .alloc_addr   (mem_addr),
        .retire_tag   (mem_data_tag),
        .lookup_addr  (cand_addr),
        .lookup_hit   (mshr_lookup_hit),
        .full         (mshr_full),
        .retire_valid (fill_valid),
        .retire_addr  (fill_addr)
    );

    inst_select select_0 (
        .fetch_pc   (fetch_pc),
        .ibuff_open (ibuff_open),
        .read_hit   (cache_read_hit),
        .read_data  (cache_read_data),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (mem_data),
        .sel_insts  (sel_insts),
        .sel_count  (sel_count)
    );

endmodule

//--- test/mem_model.sv
module mem_model (
    input  logic                    clock,

    // request side, held by fetch until accepted
    input  logic                    mem_en,
    input  fetch_pkg::addr_t        mem_addr,
    input  fetch_pkg::mem_command_t mem_command,

    output logic                    mem_transaction_handshake,
    output fetch_pkg::mem_tag_t     mem_transaction_tag,
    output fetch_pkg::mem_tag_t     mem_data_tag,
    output fetch_pkg::block_t       mem_data
);
    import fetch_pkg::*;

    // one slot per tag, tag 0 is never handed out
    logic  busy [NUM_MEM_TAGS];
    addr_t held_addr [NUM_MEM_TAGS];
    int    due [NUM_MEM_TAGS];
    int    cycle;
    int    ret_tag;
    int    new_tag;
    int    start;
    int    t;

    // memory contents, a fixed mix of the word address
    function automatic logic [31:0] mem_word(input addr_t addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    initial begin
        mem_transaction_handshake = 1'b0;
        mem_transaction_tag = '0;
        mem_data_tag = '0;
        mem_data = '0;
        cycle = 0;
        for (int i = 0; i < NUM_MEM_TAGS; i++) begin
            busy[i] = 1'b0;
            held_addr[i] = '0;
            due[i] = 0;
        end
        forever begin
            @(negedge clock);
            cycle++;
            mem_transaction_handshake = 1'b0;
            mem_transaction_tag = '0;
            mem_data_tag = '0;
            mem_data = '0;
            // scan from a random tag so due blocks come back out of order
            ret_tag = 0;
            start = $urandom_range(1, NUM_MEM_TAGS - 1);
            for (int i = 0; i < NUM_MEM_TAGS - 1; i++) begin
                t = 1 + (start - 1 + i) % (NUM_MEM_TAGS - 1);
                if (ret_tag == 0 && busy[t] && due[t] <= cycle) begin
                    ret_tag = t;
                end
            end
            if (ret_tag != 0) begin
                mem_data_tag = mem_tag_t'(ret_tag);
                mem_data = {mem_word(held_addr[ret_tag] + 32'd4), mem_word(held_addr[ret_tag])};
            end
            // accept about two thirds of the time, only with a free tag
            if (mem_en && mem_command == MEM_LOAD && $urandom_range(0, 2) != 0) begin
                new_tag = 0;
                start = $urandom_range(1, NUM_MEM_TAGS - 1);
                for (int i = 0; i < NUM_MEM_TAGS - 1; i++) begin
                    t = 1 + (start - 1 + i) % (NUM_MEM_TAGS - 1);
                    if (new_tag == 0 && !busy[t]) begin
                        new_tag = t;
                    end
                end
                if (new_tag != 0) begin
                    mem_transaction_handshake = 1'b1;
                    mem_transaction_tag = mem_tag_t'(new_tag);
                    busy[new_tag] = 1'b1;
                    held_addr[new_tag] = mem_addr;
                    due[new_tag] = cycle + $urandom_range(3, 20);
                end
            end
            // returning tag stays busy through this cycle
            if (ret_tag != 0) begin
                busy[ret_tag] = 1'b0;
            end
        end
    end

endmodule

//--- test/fetch_checker.sv
module fetch_checker (
    input  logic                    clock,
    input  logic                    rst,
    input  int                      phase,

    // DUT inputs
    input  fetch_pkg::addr_t        target,
    input  fetch_pkg::br_task_t     br_task,
    input  fetch_pkg::ibuff_count_t ibuff_open,
    input  logic                    mem_transaction_handshake,
    input  fetch_pkg::mem_tag_t     mem_transaction_tag,
    input  fetch_pkg::mem_tag_t     mem_data_tag,

    // DUT outputs
    input  logic                    mem_en,
    input  fetch_pkg::addr_t        mem_addr,
    input  fetch_pkg::mem_command_t mem_command,
    input  fetch_pkg::inst_packet_t [fetch_pkg::FETCH_WIDTH-1:0] out_insts,
    input  fetch_pkg::ibuff_count_t num_insts,

    output int                      errors,
    output int                      tests_failed,
    output int                      insts_total,
    output logic                    target_pending
);
    import fetch_pkg::*;

    // longest wait for a redirect target under heavy back-pressure
    localparam int TARGET_LIMIT = 400;

    int           cur_phase;
    int           phase_errors;
    int           phase_insts;
    int           pending_age;
    int           outstanding;
    int           words_left;
    addr_t        exp_pc;
    addr_t        slot_pc;
    ibuff_count_t prev_open;
    logic         prev_rst;
    logic         prev_clear;
    logic         redirect;
    logic         accept;
    logic         tag_busy [NUM_MEM_TAGS];
    addr_t        tag_addr [NUM_MEM_TAGS];

    // expected instruction word at a byte address
    function automatic logic [31:0] ref_inst(input addr_t addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic string test_name(input int p);
        case (p)
            0: return "sequential";
            1: return "redirects";
            2: return "back_pressure";
            3: return "redirect_burst";
            default: return "after_tests";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("Fail %s: %s expected %h actual %h",
                 test_name(cur_phase), what, exp_val, act_val);
        errors++;
        phase_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("Error in test %s: %s", test_name(cur_phase), what);
        errors++;
        phase_errors++;
    endtask

    task automatic clear_tags();
        for (int i = 0; i < NUM_MEM_TAGS; i++) begin
            tag_busy[i] = 1'b0;
        end
        outstanding = 0;
    endtask

    // summary line per test and its progress check
    task automatic finish_test();
        if (phase_insts == 0) begin
            report_problem("no instructions were emitted during the test");
        end
        if (phase_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d instructions, %0d errors", test_name(cur_phase),
                 (phase_errors == 0) ? "passed" : "failed", phase_insts, phase_errors);
        phase_errors = 0;
        phase_insts = 0;
    endtask

    task automatic check_outputs();
        // outputs are cleared by the edge after reset or redirect
        if (prev_clear && num_insts != '0) begin
            report_mismatch("num_insts after reset or redirect", 32'd0, 32'(num_insts));
        end
        if (prev_rst && mem_en) begin
            report_problem("mem_en high in the first cycle after reset");
        end
        if (int'(num_insts) > FETCH_WIDTH) begin
            report_mismatch("num_insts above fetch width", FETCH_WIDTH, 32'(num_insts));
        end
        if (!prev_clear && num_insts > prev_open) begin
            report_mismatch("num_insts above buffer room", 32'(prev_open), 32'(num_insts));
        end
        if (num_insts != '0) begin
            words_left = 2 - int'(out_insts[0].pc[2]);
            if (int'(num_insts) > words_left) begin
                report_problem("packets run past the end of the pc's block");
            end
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_pc = exp_pc + addr_t'(4 * i);
            if (i < int'(num_insts)) begin
                if (!out_insts[i].valid) begin
                    report_problem($sformatf("packet %0d is counted but not valid", i));
                end
                if (out_insts[i].pc != slot_pc) begin
                    report_mismatch($sformatf("pc of packet %0d", i), slot_pc, out_insts[i].pc);
                end
                if (out_insts[i].inst != ref_inst(out_insts[i].pc)) begin
                    report_mismatch($sformatf("inst at %h", out_insts[i].pc),
                                    ref_inst(out_insts[i].pc), out_insts[i].inst);
                end
                if (out_insts[i].npc != out_insts[i].pc + 32'd4) begin
                    report_mismatch($sformatf("npc at %h", out_insts[i].pc),
                                    out_insts[i].pc + 32'd4, out_insts[i].npc);
                end
            end else if (out_insts[i].valid) begin
                report_problem($sformatf("packet %0d is valid beyond num_insts", i));
            end
        end
        // the first emission after a redirect is its target
        if (num_insts != '0) begin
            target_pending = 1'b0;
        end
        exp_pc = exp_pc + addr_t'(4 * int'(num_insts));
        phase_insts += int'(num_insts);
        insts_total += int'(num_insts);
    endtask

    task automatic check_memory();
        if (mem_en != (mem_command == MEM_LOAD)) begin
            report_problem("mem_command does not follow mem_en");
        end
        if (mem_en && mem_addr[2:0] != 3'b000) begin
            report_mismatch("request block alignment", {mem_addr[31:3], 3'b000}, mem_addr);
        end
        if (mem_en && outstanding >= NUM_MEM_TAGS - 1) begin
            report_problem("request raised while every tag is outstanding");
        end
        // unknown tags are old-path returns
        if (mem_data_tag != '0 && tag_busy[mem_data_tag]) begin
            tag_busy[mem_data_tag] = 1'b0;
            outstanding--;
        end
        if (accept && !redirect) begin
            for (int t = 1; t < NUM_MEM_TAGS; t++) begin
                if (tag_busy[t] && tag_addr[t][31:3] == mem_addr[31:3]) begin
                    report_problem($sformatf("block %h requested while outstanding", mem_addr));
                end
            end
            tag_busy[mem_transaction_tag] = 1'b1;
            tag_addr[mem_transaction_tag] = mem_addr;
            outstanding++;
        end
    endtask

    initial begin
        errors = 0;
        tests_failed = 0;
        insts_total = 0;
        target_pending = 1'b0;
        cur_phase = 0;
        phase_errors = 0;
        phase_insts = 0;
        pending_age = 0;
        exp_pc = '0;
        prev_open = '0;
        prev_rst = 1'b1;
        prev_clear = 1'b1;
        clear_tags();
        forever begin
            @(posedge clock);
            if (phase != cur_phase) begin
                finish_test();
                cur_phase = phase;
            end
            if (rst) begin
                // reset restarts fetch at address zero
                exp_pc = '0;
                prev_open = '0;
                prev_rst = 1'b1;
                prev_clear = 1'b1;
                target_pending = 1'b1;
                pending_age = 0;
                clear_tags();
            end else begin
                redirect = (br_task != BR_NONE);
                accept = mem_en && mem_transaction_handshake && (mem_transaction_tag != '0);
                check_outputs();
                check_memory();
                if (target_pending) begin
                    pending_age++;
                    if (pending_age > TARGET_LIMIT) begin
                        report_problem("redirect target was never emitted");
                        target_pending = 1'b0;
                    end
                end
                if (redirect) begin
                    exp_pc = target;
                    target_pending = 1'b1;
                    pending_age = 0;
                    clear_tags();
                end
                prev_open = ibuff_open;
                prev_rst = 1'b0;
                prev_clear = redirect;
            end
        end
    end

endmodule

//--- test/fetch_tb.sv
module fetch_tb;
    import fetch_pkg::*;

    localparam logic [31:0] SEED = 32'hc2879386;
    localparam int NUM_TESTS = 4;
    localparam int RUN_CYCLES = 3000;
    // run plus room for the final drain
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;

    logic         clock = 1'b0;
    logic         rst;
    addr_t        target;
    br_task_t     br_task;
    ibuff_count_t ibuff_open;
    int           phase;
    int           cycle_count = 0;

    // memory wires
    logic         mem_en;
    addr_t        mem_addr;
    mem_command_t mem_command;
    logic         mem_transaction_handshake;
    mem_tag_t     mem_transaction_tag;
    mem_tag_t     mem_data_tag;
    block_t       mem_data;

    inst_packet_t [FETCH_WIDTH-1:0] out_insts;
    ibuff_count_t                   num_insts;

    // checker results
    int   errors;
    int   tests_failed;
    int   insts_total;
    logic target_pending;

    always #10 clock = ~clock;

    // cycles per test, adding up to the run length
    function automatic int test_length(input int p);
        case (p)
            0: return 600;
            1: return 1500;
            2: return 600;
            default: return 300;
        endcase
    endfunction

    // buffer room and redirect pulses for one cycle
    task automatic drive_inputs(input int p);
        int redirect_odds;
        redirect_odds = (p == 1) ? 40 : (p == 2) ? 100 : (p == 3) ? 6 : 0;
        if (p == 2 && $urandom_range(0, 3) != 0) begin
            ibuff_open = '0;
        end else begin
            ibuff_open = ibuff_count_t'($urandom_range(0, FETCH_WIDTH));
        end
        br_task = BR_NONE;
        if (redirect_odds != 0 && $urandom_range(1, redirect_odds) == 1) begin
            br_task = ($urandom_range(0, 1) == 0) ? BR_TAKEN : BR_SQUASH;
            // word aligned inside the first 1 KB
            target = addr_t'($urandom_range(0, 255)) << 2;
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        target = '0;
        br_task = BR_NONE;
        ibuff_open = '0;
        phase = 0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int p = 0; p < NUM_TESTS; p++) begin
            phase = p;
            repeat (test_length(p)) begin
                drive_inputs(p);
                @(negedge clock);
            end
        end
        // drain until the last redirect target shows up
        br_task = BR_NONE;
        ibuff_open = ibuff_count_t'(FETCH_WIDTH);
        while (target_pending) begin
            @(negedge clock);
        end
        phase = NUM_TESTS;
        repeat (2) @(negedge clock);
        $display("tests %0d, failed %0d, instructions %0d, errors %0d",
                 NUM_TESTS, tests_failed, insts_total, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    fetch uut (
        .clock                     (clock),
        .rst                       (rst),
        .target                    (target),
        .br_task                   (br_task),
        .ibuff_open                (ibuff_open),
        .mem_transaction_tag       (mem_transaction_tag),
        .mem_transaction_handshake (mem_transaction_handshake),
        .mem_data_tag              (mem_data_tag),
        .mem_data                  (mem_data),
        .mem_en                    (mem_en),
        .mem_addr                  (mem_addr),
        .mem_command               (mem_command),
        .out_insts                 (out_insts),
        .num_insts                 (num_insts)
    );

    mem_model memory_0 (
        .clock                     (clock),
        .mem_en                    (mem_en),
        .mem_addr                  (mem_addr),
        .mem_command               (mem_command),
        .mem_transaction_handshake (mem_transaction_handshake),
        .mem_transaction_tag       (mem_transaction_tag),
        .mem_data_tag              (mem_data_tag),
        .mem_data                  (mem_data)
    );

    fetch_checker checker_0 (
        .clock                     (clock),
        .rst                       (rst),
        .phase                     (phase),
        .target                    (target),
        .br_task                   (br_task),
        .ibuff_open                (ibuff_open),
        .mem_transaction_handshake (mem_transaction_handshake),
        .mem_transaction_tag       (mem_transaction_tag),
        .mem_data_tag              (mem_data_tag),
        .mem_en                    (mem_en),
        .mem_addr                  (mem_addr),
        .mem_command               (mem_command),
        .out_insts                 (out_insts),
        .num_insts                 (num_insts),
        .errors                    (errors),
        .tests_failed              (tests_failed),
        .insts_total               (insts_total),
        .target_pending            (target_pending)
    );

endmodule

//--- flist.f
common/fetch_pkg.sv
source/inst_select.sv
fetch/icache.sv
fetch/mshr_table.sv
fetch/fetch.sv
test/mem_model.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f flist.f \
    --top-module fetch_tb \
    -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

echo "simulation passed"
